// File: Bender.yml
package:
  name: game_menu

sources:
  - src/game_pkg.sv
  - src/vga_timing.sv
  - src/draw_background.sv
  - src/game_screen.sv
  - src/game_control.sv
  - src/game_top.sv
  - target: test
    files:
      - tb/game_top_tb.sv

// File: project.f
src/game_pkg.sv
src/vga_timing.sv
src/draw_background.sv
src/game_screen.sv
src/game_control.sv
src/game_top.sv
tb/game_top_tb.sv

// File: src/draw_background.sv
// Playfield background stage
`timescale 1ns/1ps
`default_nettype none

module draw_background (
    input  wire                   clk,
    input  wire                   rst,
    input  wire game_pkg::vga_beat_t beat_in,
    output game_pkg::vga_beat_t   beat_out
);
    import game_pkg::*;

    logic        visible;
    logic [11:0] rgb_nxt;

    // black outside the active area.
    assign visible = !beat_in.hblnk && !beat_in.vblnk;
    assign rgb_nxt = visible ? COLOR_BG : COLOR_BLANK;

    // one cycle delay, timing fields follow the colour.
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_out <= '0;
        end else begin
            beat_out     <= beat_in;
            beat_out.rgb <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// File: src/game_control.sv
// Game state controller
`timescale 1ns/1ps
`default_nettype none

module game_control (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    game_start,
    input  wire                    game_over,
    output game_pkg::game_state_t  state
);
    import game_pkg::*;

    game_state_t state_nxt;

    // ====================
    // next state
    // ====================

    always_comb begin
        state_nxt = state;
        case (state)
            GAME_MENU: begin
                if (game_start) begin
                    state_nxt = GAME_PLAY;
                end
            end
            GAME_PLAY: begin
                if (game_over) begin
                    state_nxt = GAME_OVER;
                end
            end
            GAME_OVER: begin
                if (game_start) begin
                    state_nxt = GAME_MENU;
                end
            end
            default: state_nxt = GAME_MENU;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= GAME_MENU;
        end else begin
            state <= state_nxt;
        end
    end

    // encoding 3 is unused.
    a_state_legal: assert property (
        @(posedge clk) disable iff (rst)
        state inside {GAME_MENU, GAME_PLAY, GAME_OVER}
    ) else $error("illegal game state %0d", state);

endmodule

`default_nettype wire

// File: src/game_pkg.sv
// Game menu shared definitions
`default_nettype none

package game_pkg;

    // ====================
    // raster timing, 800x600 at 60 Hz
    // ====================

    // horizontal counts in pixels.
    localparam integer HOR_PIXELS     = 800;
    localparam integer HOR_TOTAL      = 1056;
    localparam integer HOR_SYNC_START = 840;
    localparam integer HOR_SYNC_END   = 968;

    // vertical counts in lines.
    localparam integer VER_PIXELS     = 600;
    localparam integer VER_TOTAL      = 628;
    localparam integer VER_SYNC_START = 601;
    localparam integer VER_SYNC_END   = 605;

    // ====================
    // button geometry
    // ====================

    localparam integer BTN_W      = 125;
    localparam integer BTN_H      = 75;
    // centred horizontally, upper third vertically.
    localparam integer BTN_X      = (HOR_PIXELS - BTN_W) / 2;
    localparam integer BTN_Y      = (VER_PIXELS - BTN_H) / 3;
    localparam integer BTN_BORDER = 2;

    // dead time after an accepted click, in cycles.
    localparam integer CLICK_COOLDOWN = 20;
    localparam integer COOLDOWN_W     = $clog2(CLICK_COOLDOWN + 1);

    // ====================
    // colours, 4 bits per channel
    // ====================

    localparam logic [11:0] COLOR_BG     = 12'h124;
    localparam logic [11:0] COLOR_BORDER = 12'hFFF;
    localparam logic [11:0] COLOR_START  = 12'h0A0;
    localparam logic [11:0] COLOR_AGAIN  = 12'hA00;
    localparam logic [11:0] COLOR_BLANK  = 12'h000;

    // ====================
    // types
    // ====================

    // one raster beat, passed between all stages.
    typedef struct packed {
        logic [10:0] hcount;
        logic [9:0]  vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb;
    } vga_beat_t;

    typedef enum logic [1:0] {
        GAME_MENU = 2'd0,
        GAME_PLAY = 2'd1,
        GAME_OVER = 2'd2
    } game_state_t;

    // zero means no class chosen yet.
    typedef logic [1:0] char_class_t;

endpackage

`default_nettype wire

// File: src/game_screen.sv
// Start and restart button overlay
`timescale 1ns/1ps
`default_nettype none

module game_screen (
    input  wire                      clk,
    input  wire                      rst,
    input  wire game_pkg::game_state_t state,
    input  wire game_pkg::char_class_t char_class,
    input  wire game_pkg::char_class_t player_2_class,
    input  wire                      player_2_valid,
    input  wire [11:0]               mouse_x,
    input  wire [11:0]               mouse_y,
    input  wire                      mouse_clicked,
    output logic                     game_start,
    input  wire game_pkg::vga_beat_t beat_in,
    output game_pkg::vga_beat_t      beat_out
);
    import game_pkg::*;

    logic                  pix_in_rect;
    logic                  pix_on_border;
    logic [10:0]           rel_x;
    logic [9:0]            rel_y;
    logic [11:0]           rgb_nxt;
    logic                  click_in_rect;
    logic                  classes_ok;
    logic                  state_ok;
    logic                  click_ok;
    logic [COOLDOWN_W-1:0] cooldown;

    // ====================
    // button drawing
    // ====================

    assign pix_in_rect = (beat_in.hcount >= BTN_X) && (beat_in.hcount < BTN_X + BTN_W) &&
                         (beat_in.vcount >= BTN_Y) && (beat_in.vcount < BTN_Y + BTN_H);

    // offsets from the top-left corner, only meaningful inside the rectangle.
    assign rel_x = beat_in.hcount - 11'(BTN_X);
    assign rel_y = beat_in.vcount - 10'(BTN_Y);

    assign pix_on_border = (rel_x < BTN_BORDER) || (rel_x >= BTN_W - BTN_BORDER) ||
                           (rel_y < BTN_BORDER) || (rel_y >= BTN_H - BTN_BORDER);

    always_comb begin
        rgb_nxt = beat_in.rgb;
        if (pix_in_rect) begin
            case (state)
                GAME_MENU: rgb_nxt = pix_on_border ? COLOR_BORDER : COLOR_START;
                GAME_OVER: rgb_nxt = pix_on_border ? COLOR_BORDER : COLOR_AGAIN;
                default:   rgb_nxt = beat_in.rgb;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_out <= '0;
        end else begin
            beat_out     <= beat_in;
            beat_out.rgb <= rgb_nxt;
        end
    end

    // ====================
    // click detection
    // ====================

    assign click_in_rect = (mouse_x >= BTN_X) && (mouse_x < BTN_X + BTN_W) &&
                           (mouse_y >= BTN_Y) && (mouse_y < BTN_Y + BTN_H);

    // player 2 must pick a different, non-zero class when present.
    always_comb begin
        classes_ok = (char_class != '0);
        if (player_2_valid) begin
            classes_ok = classes_ok && (player_2_class != '0) &&
                         (player_2_class != char_class);
        end
    end

    assign state_ok = (state == GAME_OVER) || ((state == GAME_MENU) && classes_ok);
    assign click_ok = mouse_clicked && click_in_rect && (cooldown == '0) && state_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            game_start <= 1'b0;
            cooldown   <= '0;
        end else begin
            game_start <= click_ok;
            if (click_ok) begin
                cooldown <= COOLDOWN_W'(CLICK_COOLDOWN);
            end else if (cooldown != '0) begin
                cooldown <= cooldown - 1'b1;
            end
        end
    end

    // cooldown keeps the start pulse to a single cycle.
    a_start_single: assert property (
        @(posedge clk) disable iff (rst)
        game_start |=> !game_start
    ) else $error("game_start held for more than one cycle");

    // state from game_control has not yet moved when the pulse is seen.
    a_start_not_play: assert property (
        @(posedge clk) disable iff (rst)
        game_start |-> (state != GAME_PLAY)
    ) else $error("game_start raised during play");

endmodule

`default_nettype wire

// File: src/game_top.sv
// Game menu top level
`timescale 1ns/1ps
`default_nettype none

module game_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire [11:0]               mouse_x,
    input  wire [11:0]               mouse_y,
    input  wire                      mouse_clicked,
    input  wire game_pkg::char_class_t char_class,
    input  wire game_pkg::char_class_t player_2_class,
    input  wire                      player_2_valid,
    input  wire                      game_over,
    output game_pkg::game_state_t    state,
    output game_pkg::vga_beat_t      vga
);
    import game_pkg::*;

    // raster links between stages.
    vga_beat_t beat_timing;
    vga_beat_t beat_bg;
    logic      game_start;

    vga_timing u_vga_timing (
        .clk  (clk),
        .rst  (rst),
        .beat (beat_timing)
    );

    draw_background u_draw_background (
        .clk      (clk),
        .rst      (rst),
        .beat_in  (beat_timing),
        .beat_out (beat_bg)
    );

    game_screen u_game_screen (
        .clk            (clk),
        .rst            (rst),
        .state          (state),
        .char_class     (char_class),
        .player_2_class (player_2_class),
        .player_2_valid (player_2_valid),
        .mouse_x        (mouse_x),
        .mouse_y        (mouse_y),
        .mouse_clicked  (mouse_clicked),
        .game_start     (game_start),
        .beat_in        (beat_bg),
        .beat_out       (vga)
    );

    game_control u_game_control (
        .clk        (clk),
        .rst        (rst),
        .game_start (game_start),
        .game_over  (game_over),
        .state      (state)
    );

endmodule

`default_nettype wire

// File: src/vga_timing.sv
// VGA raster timing generator
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  wire                   clk,
    input  wire                   rst,
    output game_pkg::vga_beat_t   beat
);
    import game_pkg::*;

    logic [10:0] hcount_nxt;
    logic [9:0]  vcount_nxt;
    logic        line_end;
    logic        frame_end;

    // ====================
    // next position
    // ====================

    assign line_end  = (beat.hcount == 11'(HOR_TOTAL - 1));
    assign frame_end = (beat.vcount == 10'(VER_TOTAL - 1));

    always_comb begin
        hcount_nxt = beat.hcount + 11'd1;
        vcount_nxt = beat.vcount;
        if (line_end) begin
            hcount_nxt = '0;
            if (frame_end) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = beat.vcount + 10'd1;
            end
        end
    end

    // ====================
    // beat register
    // ====================

    // sync and blank are decoded from the next position,
    // so every field of the beat lines up in the same cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            beat <= '0;
        end else begin
            beat.hcount <= hcount_nxt;
            beat.vcount <= vcount_nxt;
            beat.hsync  <= (hcount_nxt >= HOR_SYNC_START) && (hcount_nxt < HOR_SYNC_END);
            beat.vsync  <= (vcount_nxt >= VER_SYNC_START) && (vcount_nxt < VER_SYNC_END);
            beat.hblnk  <= (hcount_nxt >= HOR_PIXELS);
            beat.vblnk  <= (vcount_nxt >= VER_PIXELS);
            beat.rgb    <= COLOR_BLANK;
        end
    end

    // counter stays in range.
    a_hcount_range: assert property (
        @(posedge clk) disable iff (rst)
        beat.hcount < 11'(HOR_TOTAL)
    ) else $error("hcount out of range: %0d", beat.hcount);

endmodule

`default_nettype wire

// File: tb/game_top_tb.sv
// Game top testbench
`timescale 1ns/1ps
`default_nettype none

module game_top_tb;
    import game_pkg::*;

    logic        clk;
    logic        rst;
    logic [11:0] mouse_x;
    logic [11:0] mouse_y;
    logic        mouse_clicked;
    char_class_t char_class;
    char_class_t player_2_class;
    logic        player_2_valid;
    logic        game_over;
    game_state_t state;
    vga_beat_t   vga;

    // test vectors, one entry per line of the file.
    string       vec_op[$];
    int          vec_x[$];
    int          vec_y[$];
    int          vec_c1[$];
    int          vec_c2[$];
    int          vec_v[$];
    int          vec_exp[$];

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 0;
    logic [31:0] rnd_state = 32'd45;

    game_top uut (
        .clk            (clk),
        .rst            (rst),
        .mouse_x        (mouse_x),
        .mouse_y        (mouse_y),
        .mouse_clicked  (mouse_clicked),
        .char_class     (char_class),
        .player_2_class (player_2_class),
        .player_2_valid (player_2_valid),
        .game_over      (game_over),
        .state          (state),
        .vga            (vga)
    );

    always #50 clk = ~clk;

    // run limit, two frames plus headroom per vector.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, the vectors did not complete", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ====================
    // helpers
    // ====================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic in_button(input int x, input int y);
        return (x >= BTN_X) && (x < BTN_X + BTN_W) && (y >= BTN_Y) && (y < BTN_Y + BTN_H);
    endfunction

    function automatic logic classes_valid(input int c1, input int c2, input int v);
        if (c1 == 0) begin
            return 1'b0;
        end
        if (v != 0) begin
            return (c2 != 0) && (c2 != c1);
        end
        return 1'b1;
    endfunction

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // sync and blank flags of the output beat against the raster constants.
    task automatic check_sync_blank();
        logic [3:0] expected;
        expected[3] = (vga.hcount >= HOR_SYNC_START) && (vga.hcount < HOR_SYNC_END);
        expected[2] = (vga.vcount >= VER_SYNC_START) && (vga.vcount < VER_SYNC_END);
        expected[1] = (vga.hcount >= HOR_PIXELS);
        expected[0] = (vga.vcount >= VER_PIXELS);
        compare_values("vga.{hsync,vsync,hblnk,vblnk}", 32'(expected),
                       32'({vga.hsync, vga.vsync, vga.hblnk, vga.vblnk}));
    endtask

    task automatic read_vectors();
        int    fd;
        int    n;
        int    status;
        string line;
        string op;
        int    x;
        int    y;
        int    c1;
        int    c2;
        int    v;
        int    e;
        fd = $fopen("tb/game_top_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the vector file tb/game_top_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                status = $fgets(line, fd);
                if (status == 0 || line.len() == 0 || line[0] == "#") begin
                    continue;
                end
                n = $sscanf(line, "%s %d %d %d %d %d %h", op, x, y, c1, c2, v, e);
                if (n == 7) begin
                    vec_op.push_back(op);
                    vec_x.push_back(x);
                    vec_y.push_back(y);
                    vec_c1.push_back(c1);
                    vec_c2.push_back(c2);
                    vec_v.push_back(v);
                    vec_exp.push_back(e);
                end
            end
            $fclose(fd);
        end
    endtask

    // one-cycle click, returns once the state has had time to move.
    task automatic click_at(input int x, input int y, input int c1, input int c2, input int v);
        @(posedge clk);
        mouse_x        <= x[11:0];
        mouse_y        <= y[11:0];
        char_class     <= c1[1:0];
        player_2_class <= c2[1:0];
        player_2_valid <= v[0];
        mouse_clicked  <= 1'b1;
        @(posedge clk);
        mouse_clicked  <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic pulse_game_over();
        @(posedge clk);
        game_over <= 1'b1;
        @(posedge clk);
        game_over <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
    endtask

    // every beat seen on the way is checked for sync and blank.
    task automatic wait_for_pixel(input int x, input int y);
        @(negedge clk);
        check_sync_blank();
        while (!(vga.hcount == x && vga.vcount == y)) begin
            @(negedge clk);
            check_sync_blank();
        end
    endtask

    // random positions around the button until one is accepted.
    task automatic random_clicks(input int c1, input int c2, input int v);
        int   x;
        int   y;
        int   tries;
        logic accept;
        accept = 1'b0;
        tries = 0;
        while (!accept && tries < 16) begin
            rnd_state = xorshift32(rnd_state);
            x = 300 + int'(rnd_state % 200);
            rnd_state = xorshift32(rnd_state);
            y = 150 + int'(rnd_state % 128);
            accept = in_button(x, y) && classes_valid(c1, c2, v);
            click_at(x, y, c1, c2, v);
            compare_values("state", 32'(accept ? GAME_PLAY : GAME_MENU), 32'(state));
            tries++;
        end
        if (!accept) begin
            accept = classes_valid(c1, c2, v);
            click_at(BTN_X + BTN_W / 2, BTN_Y + BTN_H / 2, c1, c2, v);
            compare_values("state", 32'(accept ? GAME_PLAY : GAME_MENU), 32'(state));
        end
    endtask

    // ====================
    // main sequence
    // ====================

    initial begin
        int i;
        int errs_before;
        clk            = 1'b0;
        rst            = 1'b1;
        mouse_x        = '0;
        mouse_y        = '0;
        mouse_clicked  = 1'b0;
        char_class     = '0;
        player_2_class = '0;
        player_2_valid = 1'b0;
        game_over      = 1'b0;
        read_vectors();
        limit = 2 * HOR_TOTAL * VER_TOTAL + 1000 * vec_op.size();
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // reset state, then the raster counts up from the origin.
        @(negedge clk);
        compare_values("state", 32'(GAME_MENU), 32'(state));
        compare_values("vga.hcount", 32'd0, 32'(vga.hcount));
        compare_values("vga.vcount", 32'd0, 32'(vga.vcount));
        while (vga.hcount == 0) begin
            @(negedge clk);
        end
        compare_values("vga.hcount", 32'd1, 32'(vga.hcount));
        @(negedge clk);
        compare_values("vga.hcount", 32'd2, 32'(vga.hcount));
        $display("test 0 RESET %s", (errors == 0) ? "ok" : "failed");

        for (i = 0; i < vec_op.size(); i++) begin
            errs_before = errors;
            if (vec_op[i] == "PIXEL") begin
                wait_for_pixel(vec_x[i], vec_y[i]);
                compare_values("vga.rgb", 32'(vec_exp[i]), 32'(vga.rgb));
            end else if (vec_op[i] == "CLICK") begin
                click_at(vec_x[i], vec_y[i], vec_c1[i], vec_c2[i], vec_v[i]);
                compare_values("state", 32'(vec_exp[i]), 32'(state));
            end else if (vec_op[i] == "RAND") begin
                random_clicks(vec_c1[i], vec_c2[i], vec_v[i]);
                compare_values("state", 32'(vec_exp[i]), 32'(state));
                // let the cooldown of the accepted click run out.
                repeat (CLICK_COOLDOWN) @(posedge clk);
                @(negedge clk);
            end else if (vec_op[i] == "OVER") begin
                pulse_game_over();
                compare_values("state", 32'(vec_exp[i]), 32'(state));
            end else if (vec_op[i] == "IDLE") begin
                repeat (vec_x[i]) @(posedge clk);
                @(negedge clk);
                compare_values("state", 32'(vec_exp[i]), 32'(state));
            end else begin
                errors++;
                $display("unknown operation %s in vector %0d", vec_op[i], i + 1);
            end
            $display("test %0d %s %s", i + 1, vec_op[i], (errors == errs_before) ? "ok" : "failed");
        end

        $display("%0d tests, %0d checks, %0d errors", vec_op.size() + 1, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/game_top_vectors.txt
# op x y char_class player_2_class player_2_valid expected(hex)
# PIXEL expects rgb, other operations expect the state; IDLE waits x cycles
PIXEL 100 100 0 0 0 124
PIXEL 337 175 0 0 0 fff
PIXEL 400 200 0 0 0 0a0
PIXEL 461 200 0 0 0 fff
PIXEL 900 300 0 0 0 000
CLICK 400 200 0 0 0 0
CLICK 400 200 1 1 1 0
CLICK 400 200 1 0 1 0
CLICK 100 100 1 2 1 0
RAND 0 0 1 2 1 1
CLICK 400 200 1 2 1 1
PIXEL 400 200 0 0 0 124
OVER 0 0 0 0 0 2
PIXEL 400 240 0 0 0 a00
CLICK 400 200 0 0 0 0
CLICK 400 200 1 2 1 0
IDLE 25 0 0 0 0 0
CLICK 400 200 3 0 0 1
OVER 0 0 0 0 0 2
IDLE 25 0 0 0 0 2
CLICK 400 200 0 0 0 0
